// File: files.f
+incdir+include
hdl/boot_ctrl_pkg.sv
hdl/boot_reg_pkg.sv
hdl/boot_sequencer.sv
hdl/boot_ctrl_regs.sv
hdl/boot_ctrl_top.sv
testbench/tb_boot_ctrl.sv

// File: Makefile
# Verilator flow for the boot controller testbench

TOP := tb_boot_ctrl
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module boot_ctrl_top hdl/boot_ctrl_top.sv
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) -o V$(TOP)
	-./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_boot_ctrl.sv
//==========================================================================
// boot controller testbench
// directed tests of cold boot, the fuse lock, the firmware-update reset,
// warm reset, the breakpoint strap and the scan-mode override
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "boot_ctrl_defines.svh"

module tb_boot_ctrl;

    // limits in clock cycles, except STATE_POLLS which counts status reads
    localparam int READ_TIMEOUT  = 8;
    localparam int STATE_POLLS   = 20;
    localparam int LEVEL_TIMEOUT = 40;
    localparam int UPD_TIMEOUT   = 200;

    logic                    clk;
    logic                    cptra_pwrgood;
    logic                    cptra_rst_b;
    logic                    scan_mode;
    logic                    brkpoint;
    logic                    req_valid;
    boot_reg_pkg::reg_req_t  req;
    logic                    rd_valid;
    logic [`BOOT_DATA_W-1:0] rdata;
    boot_ctrl_pkg::rst_out_t rst_out;
    logic                    iccm_unlock;

    // fuse values written during cold boot, kept for the readback checks
    integer                  seed;
    logic [`BOOT_DATA_W-1:0] fuse_val [`BOOT_FUSE_WORDS];

    boot_ctrl_top i_boot_ctrl_top (
        .clk           (clk),
        .cptra_pwrgood (cptra_pwrgood),
        .cptra_rst_b   (cptra_rst_b),
        .scan_mode     (scan_mode),
        .brkpoint      (brkpoint),
        .req_valid     (req_valid),
        .req           (req),
        .rd_valid      (rd_valid),
        .rdata         (rdata),
        .rst_out       (rst_out),
        .iccm_unlock   (iccm_unlock)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_data(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected 0x%08h, actual 0x%08h", test, exp, act));
        end
    endtask

    task automatic compare_state(input string test,
                                 input boot_ctrl_pkg::boot_fsm_state_e exp,
                                 input boot_ctrl_pkg::boot_fsm_state_e act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected state %s, actual state %s (%0d)",
                                test, exp.name(), act.name(), act));
        end
    endtask

    // the struct prints as {noncore_rst_b, uc_rst_b, rdc_clk_dis, fw_update_rst_window}
    task automatic compare_rst(input string test,
                               input boot_ctrl_pkg::rst_out_t exp,
                               input boot_ctrl_pkg::rst_out_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: {noncore,uc,rdc_dis,fw_win} expected %b, actual %b",
                                test, exp, act));
        end
    endtask

    function automatic boot_ctrl_pkg::rst_out_t make_rst(input logic noncore, input logic uc,
                                                         input logic rdc, input logic win);
        boot_ctrl_pkg::rst_out_t r;
        r.noncore_rst_b        = noncore;
        r.uc_rst_b             = uc;
        r.rdc_clk_dis          = rdc;
        r.fw_update_rst_window = win;
        return r;
    endfunction

    // expected status word, assembled field by field from the register layout
    function automatic logic [31:0] status_word(input boot_ctrl_pkg::boot_fsm_state_e state,
                                                input logic executed, input logic ready,
                                                input logic done, input logic uc);
        boot_reg_pkg::boot_status_t s;
        s                     = '0;
        s.fw_upd_rst_executed = executed;
        s.ready_for_fuses     = ready;
        s.fuse_done           = done;
        s.boot_state          = state;
        s.uc_rst_b            = uc;
        return s;
    endfunction

    function automatic logic [7:0] fuse_addr(input int idx);
        return 8'(`ADDR_FUSE_BASE + 4 * idx);
    endfunction

    // one request cycle, the write lands on the edge that samples req_valid
    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        boot_reg_pkg::reg_req_t r;
        r.op    = boot_reg_pkg::REG_WRITE;
        r.addr  = addr;
        r.wdata = data;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        boot_reg_pkg::reg_req_t r;
        int                     n;
        r.op    = boot_reg_pkg::REG_READ;
        r.addr  = addr;
        r.wdata = '0;
        n       = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
        // rd_valid is a single-cycle pulse, so it is sampled at every negedge
        @(negedge clk);
        while ((rd_valid !== 1'b1) && (n < READ_TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (rd_valid !== 1'b1) begin
            abort_run($sformatf("read of address 0x%02h never returned rd_valid", addr));
        end
        data = rdata;
    endtask

    task automatic wait_state(input string test, input boot_ctrl_pkg::boot_fsm_state_e want);
        logic [31:0]                    word;
        boot_reg_pkg::boot_status_t     st;
        boot_ctrl_pkg::boot_fsm_state_e seen;
        int                             polls;
        polls = 0;
        do begin
            reg_read(`ADDR_STATUS, word);
            st   = word;
            seen = boot_ctrl_pkg::boot_fsm_state_e'(st.boot_state);
            polls++;
        end while ((seen != want) && (polls < STATE_POLLS));
        if (seen != want) begin
            abort_run($sformatf("%s: the boot state never reached %s", test, want.name()));
        end
    endtask

    task automatic wait_uc_rst(input string test, input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while ((rst_out.uc_rst_b !== level) && (n < LEVEL_TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (rst_out.uc_rst_b !== level) begin
            abort_run($sformatf("%s: uc_rst_b never went to %b", test, level));
        end
    endtask

    // pulls cptra_rst_b low and waits until the clock-disable window is open
    // and both generated resets are asserted
    task automatic enter_warm_reset(input string test);
        int n;
        n = 0;
        @(posedge clk);
        cptra_rst_b <= 1'b0;
        @(negedge clk);
        while (!(rst_out.rdc_clk_dis && !rst_out.noncore_rst_b && !rst_out.uc_rst_b) &&
               (n < LEVEL_TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        compare_rst({test, " warm reset"}, make_rst(1'b0, 1'b0, 1'b1, 1'b0), rst_out);
    endtask

    task automatic leave_warm_reset();
        @(posedge clk);
        cptra_rst_b <= 1'b1;
    endtask

    task automatic cold_boot();
        logic [31:0] word;
        int          i;
        // power-good is still low here, everything must sit in reset
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_rst("cold_boot reset", make_rst(1'b0, 1'b0, 1'b1, 1'b0), rst_out);
        compare_data("cold_boot iccm_unlock", 32'd0, {31'd0, iccm_unlock});
        compare_data("cold_boot rd_valid", 32'd0, {31'd0, rd_valid});
        @(posedge clk);
        cptra_pwrgood <= 1'b1;
        cptra_rst_b   <= 1'b1;
        wait_state("cold_boot", boot_ctrl_pkg::BOOT_FUSE);
        // non-core reset leaves two cycles after the fuse state is entered
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_rst("cold_boot fuse window", make_rst(1'b1, 1'b0, 1'b0, 1'b0), rst_out);
        reg_read(`ADDR_STATUS, word);
        compare_data("cold_boot status",
                     status_word(boot_ctrl_pkg::BOOT_FUSE, 1'b0, 1'b1, 1'b0, 1'b0), word);
        for (i = 0; i < `BOOT_FUSE_WORDS; i++) begin
            fuse_val[i] = $random(seed);
            reg_write(fuse_addr(i), fuse_val[i]);
        end
        for (i = 0; i < `BOOT_FUSE_WORDS; i++) begin
            reg_read(fuse_addr(i), word);
            compare_data($sformatf("cold_boot fuse %0d", i), fuse_val[i], word);
        end
        reg_write(`ADDR_FUSE_DONE, 32'h1);
        wait_state("cold_boot", boot_ctrl_pkg::BOOT_DONE);
        wait_uc_rst("cold_boot", 1'b1);
    endtask

    task automatic fuse_lock();
        logic [31:0] word;
        int          i;
        // inverted data makes any write that slips through visible
        for (i = 0; i < `BOOT_FUSE_WORDS; i++) begin
            reg_write(fuse_addr(i), ~fuse_val[i]);
        end
        for (i = 0; i < `BOOT_FUSE_WORDS; i++) begin
            reg_read(fuse_addr(i), word);
            compare_data($sformatf("fuse_lock fuse %0d", i), fuse_val[i], word);
        end
    endtask

    task automatic fw_update_reset();
        logic [31:0] word;
        int          low_cycles;
        int          pulses;
        low_cycles = 0;
        pulses     = 0;
        reg_write(`ADDR_FW_UPDATE, 32'h0000_0C00);
        reg_read(`ADDR_FW_UPDATE, word);
        compare_data("fw_update wait cycles", 32'h0000_0C00, word);
        reg_write(`ADDR_FW_UPDATE, 32'h0000_0C01);
        wait_uc_rst("fw_update", 1'b0);
        compare_rst("fw_update core reset", make_rst(1'b1, 1'b0, 1'b0, 1'b1), rst_out);
        // count the low time and look for the unlock pulse while the core is held
        while ((rst_out.uc_rst_b === 1'b0) && (low_cycles < UPD_TIMEOUT)) begin
            if (rst_out.noncore_rst_b !== 1'b1) begin
                abort_run("fw_update: the non-core reset dropped during the core reset");
            end
            if (iccm_unlock === 1'b1) begin
                pulses++;
            end
            low_cycles++;
            @(negedge clk);
        end
        if (rst_out.uc_rst_b !== 1'b1) begin
            abort_run("fw_update: uc_rst_b never rose after the firmware-update reset");
        end
        if (low_cycles < 12) begin
            abort_run($sformatf("[FAIL] fw_update low time: expected at least 12, actual %0d",
                                low_cycles));
        end
        compare_data("fw_update iccm_unlock pulses", 32'd1, pulses);
        reg_read(`ADDR_STATUS, word);
        compare_data("fw_update status",
                     status_word(boot_ctrl_pkg::BOOT_DONE, 1'b1, 1'b0, 1'b1, 1'b1), word);
    endtask

    task automatic warm_reset();
        logic [31:0]                word;
        boot_reg_pkg::boot_status_t st;
        int                         i;
        enter_warm_reset("warm_reset");
        leave_warm_reset();
        wait_state("warm_reset", boot_ctrl_pkg::BOOT_FUSE);
        // the fuse window is open again but fuse_done still locks the words
        for (i = 0; i < `BOOT_FUSE_WORDS; i++) begin
            reg_write(fuse_addr(i), ~fuse_val[i]);
        end
        for (i = 0; i < `BOOT_FUSE_WORDS; i++) begin
            reg_read(fuse_addr(i), word);
            compare_data($sformatf("warm_reset fuse %0d", i), fuse_val[i], word);
        end
        reg_read(`ADDR_FUSE_DONE, word);
        compare_data("warm_reset fuse_done", 32'h1, word);
        // fuse_done survived, the executed bit did not
        reg_read(`ADDR_STATUS, word);
        compare_data("warm_reset status",
                     status_word(boot_ctrl_pkg::BOOT_FUSE, 1'b0, 1'b1, 1'b1, 1'b0), word);
        repeat (10) @(posedge clk);
        reg_read(`ADDR_STATUS, word);
        st = word;
        compare_state("warm_reset hold", boot_ctrl_pkg::BOOT_FUSE,
                      boot_ctrl_pkg::boot_fsm_state_e'(st.boot_state));
        reg_write(`ADDR_FUSE_DONE, 32'h1);
        wait_state("warm_reset", boot_ctrl_pkg::BOOT_DONE);
        wait_uc_rst("warm_reset", 1'b1);
    endtask

    task automatic breakpoint_hold();
        logic [31:0]                word;
        boot_reg_pkg::boot_status_t st;
        int                         i;
        @(posedge clk);
        brkpoint <= 1'b1;
        enter_warm_reset("breakpoint");
        leave_warm_reset();
        wait_state("breakpoint", boot_ctrl_pkg::BOOT_FUSE);
        reg_write(`ADDR_FUSE_DONE, 32'h1);
        wait_state("breakpoint", boot_ctrl_pkg::BOOT_WAIT);
        for (i = 0; i < 50; i++) begin
            @(negedge clk);
            if (rst_out.uc_rst_b !== 1'b0) begin
                abort_run("breakpoint: uc_rst_b was released while the breakpoint held");
            end
        end
        reg_read(`ADDR_STATUS, word);
        st = word;
        compare_state("breakpoint hold", boot_ctrl_pkg::BOOT_WAIT,
                      boot_ctrl_pkg::boot_fsm_state_e'(st.boot_state));
        // the continue bit releases the hold
        reg_write(`ADDR_BOOT_CTRL, 32'h1);
        wait_state("breakpoint", boot_ctrl_pkg::BOOT_DONE);
        wait_uc_rst("breakpoint", 1'b1);
    endtask

    task automatic scan_override();
        @(posedge clk);
        brkpoint <= 1'b0;
        enter_warm_reset("scan_mode");
        @(posedge clk);
        scan_mode <= 1'b1;
        @(negedge clk);
        compare_rst("scan_mode override", make_rst(1'b1, 1'b1, 1'b1, 1'b0), rst_out);
        @(posedge clk);
        scan_mode <= 1'b0;
        @(negedge clk);
        compare_rst("scan_mode released", make_rst(1'b0, 1'b0, 1'b1, 1'b0), rst_out);
        leave_warm_reset();
    endtask

    initial begin
        seed          = 32'h2f0;
        cptra_pwrgood <= 1'b0;
        cptra_rst_b   <= 1'b0;
        scan_mode     <= 1'b0;
        brkpoint      <= 1'b0;
        req_valid     <= 1'b0;
        req           <= '0;
        cold_boot();
        fuse_lock();
        fw_update_reset();
        warm_reset();
        breakpoint_hold();
        scan_override();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/boot_ctrl_top.sv
//==========================================================================
// boot controller top level
// register block plus the boot and reset sequencer
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "boot_ctrl_defines.svh"

module boot_ctrl_top (
    input  logic                    clk,
    input  logic                    cptra_pwrgood,
    input  logic                    cptra_rst_b,
    input  logic                    scan_mode,
    input  logic                    brkpoint,
    input  logic                    req_valid,
    input  boot_reg_pkg::reg_req_t  req,
    output logic                    rd_valid,
    output logic [`BOOT_DATA_W-1:0] rdata,
    output boot_ctrl_pkg::rst_out_t rst_out,
    output logic                    iccm_unlock
);

    // register block to sequencer
    logic       fw_update_rst;
    logic [7:0] fw_update_rst_wait_cycles;
    logic       boot_continue;
    logic       fuse_done;
    logic       fuse_wr_done_observed;

    // sequencer back to register block
    logic                           ready_for_fuses;
    logic                           fw_upd_rst_executed;
    boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps;

    boot_ctrl_regs i_boot_ctrl_regs (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_rst_b               (cptra_rst_b),
        .req_valid                 (req_valid),
        .req                       (req),
        .rd_valid                  (rd_valid),
        .rdata                     (rdata),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .boot_continue             (boot_continue),
        .fuse_done                 (fuse_done),
        .fuse_wr_done_observed     (fuse_wr_done_observed),
        .ready_for_fuses           (ready_for_fuses),
        .boot_fsm_ps               (boot_fsm_ps),
        .fw_upd_rst_executed       (fw_upd_rst_executed),
        .uc_rst_b                  (rst_out.uc_rst_b)
    );

    boot_sequencer i_boot_sequencer (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_rst_b               (cptra_rst_b),
        .scan_mode                 (scan_mode),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .brkpoint                  (brkpoint),
        .boot_continue             (boot_continue),
        .fuse_done                 (fuse_done),
        .fuse_wr_done_observed     (fuse_wr_done_observed),
        .ready_for_fuses           (ready_for_fuses),
        .fw_upd_rst_executed       (fw_upd_rst_executed),
        .iccm_unlock               (iccm_unlock),
        .boot_fsm_ps               (boot_fsm_ps),
        .rst_out                   (rst_out)
    );

endmodule

`default_nettype wire

// File: hdl/boot_ctrl_regs.sv
//==========================================================================
// boot control register block
// holds the fuse words and their lock, the firmware-update controls and
// the continue bit, and returns a status word built from sequencer state
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "boot_ctrl_defines.svh"

module boot_ctrl_regs (
    input  logic                           clk,
    input  logic                           cptra_pwrgood,
    input  logic                           cptra_rst_b,
    input  logic                           req_valid,
    input  boot_reg_pkg::reg_req_t         req,
    output logic                           rd_valid,
    output logic [`BOOT_DATA_W-1:0]        rdata,
    output logic                           fw_update_rst,
    output logic [7:0]                     fw_update_rst_wait_cycles,
    output logic                           boot_continue,
    output logic                           fuse_done,
    output logic                           fuse_wr_done_observed,
    input  logic                           ready_for_fuses,
    input  boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps,
    input  logic                           fw_upd_rst_executed,
    input  logic                           uc_rst_b
);

    localparam int FUSE_IDX_W = $clog2(`BOOT_FUSE_WORDS);
    localparam logic [`BOOT_ADDR_W-1:0] FUSE_SPAN = `BOOT_ADDR_W'(4 * `BOOT_FUSE_WORDS);

    logic [`BOOT_DATA_W-1:0] fuse_q [`BOOT_FUSE_WORDS];

    logic                    wr_req;
    logic                    rd_req;
    logic [`BOOT_ADDR_W-1:0] fuse_offset;
    logic                    fuse_hit;
    logic [FUSE_IDX_W-1:0]   fuse_idx;
    logic                    fuse_wr;
    logic                    fw_upd_rst_exec_q;
    logic [`BOOT_DATA_W-1:0] rdata_nxt;

    boot_reg_pkg::boot_status_t status;

    assign wr_req = req_valid & (req.op == boot_reg_pkg::REG_WRITE);
    assign rd_req = req_valid & (req.op == boot_reg_pkg::REG_READ);

    // word-aligned hit inside the fuse range
    assign fuse_offset = req.addr - `ADDR_FUSE_BASE;
    assign fuse_hit    = (fuse_offset < FUSE_SPAN) & (fuse_offset[1:0] == 2'b00);
    assign fuse_idx    = fuse_offset[FUSE_IDX_W+1:2];

    // fuses are writable only in the fuse window and until fuse_done locks them
    assign fuse_wr = wr_req & fuse_hit & ready_for_fuses & ~fuse_done;

    // fuse contents and the lock survive warm reset
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            for (int i = 0; i < `BOOT_FUSE_WORDS; i++) begin
                fuse_q[i] <= '0;
            end
            fuse_done <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            if (fuse_wr) begin
                fuse_q[fuse_idx] <= req.wdata;
            end
            if (wr_req && (req.addr == `ADDR_FUSE_DONE)) begin
                fuse_done <= 1'b1;
            end
            rd_valid <= rd_req;
        end
    end

    // controls that a warm reset returns to their defaults
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_wr_done_observed     <= 1'b0;
            fw_update_rst             <= 1'b0;
            fw_update_rst_wait_cycles <= `BOOT_FW_WAIT_DEFAULT;
            boot_continue             <= 1'b0;
            fw_upd_rst_exec_q         <= 1'b0;
        end else begin
            // request is a single-cycle pulse, so it reads back as zero
            fw_update_rst <= wr_req & (req.addr == `ADDR_FW_UPDATE) & req.wdata[0];
            if (wr_req && (req.addr == `ADDR_FUSE_DONE)) begin
                fuse_wr_done_observed <= 1'b1;
            end
            if (wr_req && (req.addr == `ADDR_FW_UPDATE)) begin
                fw_update_rst_wait_cycles <= req.wdata[15:8];
            end
            if (wr_req && (req.addr == `ADDR_BOOT_CTRL)) begin
                boot_continue <= req.wdata[0];
            end
            // sticky until the next warm reset
            if (fw_upd_rst_executed) begin
                fw_upd_rst_exec_q <= 1'b1;
            end
        end
    end

    always_comb begin
        status                     = '0;
        status.fw_upd_rst_executed = fw_upd_rst_exec_q;
        status.ready_for_fuses     = ready_for_fuses;
        status.fuse_done           = fuse_done;
        status.boot_state          = boot_fsm_ps;
        status.uc_rst_b            = uc_rst_b;
    end

    // read mux, unmapped addresses return zero
    always_comb begin
        rdata_nxt = '0;
        if (fuse_hit) begin
            rdata_nxt = fuse_q[fuse_idx];
        end else begin
            case (req.addr)
                `ADDR_FUSE_DONE: rdata_nxt[0] = fuse_done;
                `ADDR_FW_UPDATE: rdata_nxt[15:8] = fw_update_rst_wait_cycles;
                `ADDR_BOOT_CTRL: rdata_nxt[0] = boot_continue;
                `ADDR_STATUS:    rdata_nxt = status;
                default:         rdata_nxt = '0;
            endcase
        end
    end

    // read data is only meaningful while rd_valid is high
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rdata <= rdata_nxt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/boot_sequencer.sv
//==========================================================================
// boot and reset sequencer
// brings the non-core logic out of reset, opens the fuse window and then
// releases the microcontroller once the SoC reports the fuses written.
// also runs the firmware-update reset of the microcontroller alone and
// raises a clock-disable window around warm reset
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module boot_sequencer (
    input  logic                           clk,
    input  logic                           cptra_pwrgood,
    input  logic                           cptra_rst_b,
    input  logic                           scan_mode,
    input  logic                           fw_update_rst,
    input  logic [7:0]                     fw_update_rst_wait_cycles,
    input  logic                           brkpoint,
    input  logic                           boot_continue,
    input  logic                           fuse_done,
    input  logic                           fuse_wr_done_observed,
    output logic                           ready_for_fuses,
    output logic                           fw_upd_rst_executed,
    output logic                           iccm_unlock,
    output boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps,
    output boot_ctrl_pkg::rst_out_t        rst_out
);

    boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ns;

    // transition conditions
    logic arc_idle_fuse;
    logic arc_fuse_exit;
    logic arc_fwrst_wait;
    logic arc_wait_done;
    logic arc_done_fwrst;
    logic brk_hold;

    // reset requests from the state machine, before the two flop stages
    logic fsm_noncore_rst_b;
    logic fsm_uc_rst_b;
    logic fsm_iccm_unlock;
    logic noncore_rst_b_sync;
    logic uc_rst_b_sync;
    logic noncore_rst_b_q;
    logic uc_rst_b_q;

    // firmware-update wait counter controls
    logic       wait_count_load;
    logic       wait_count_decr;
    logic [7:0] wait_count;

    // warm reset window and its delayed copies
    logic rst_window;
    logic rst_window_f;
    logic rst_window_2f;
    logic rst_window_3f;
    logic rst_window_4f;

    // leave idle once the synchronized warm reset window has closed
    assign arc_idle_fuse = ~rst_window_f;

    // fuse_done alone is not enough after a warm reset, since it is kept
    // across it, the SoC must also be seen writing it again
    assign arc_fuse_exit = fuse_done & fuse_wr_done_observed;

    // the core reset has reached the first flop stage
    assign arc_fwrst_wait = ~uc_rst_b_sync;

    // the breakpoint strap parks the sequencer until continue is written
    assign brk_hold      = brkpoint & ~boot_continue;
    assign arc_wait_done = (wait_count == 8'd0) & ~brk_hold;

    assign arc_done_fwrst = fw_update_rst;

    always_comb begin
        boot_fsm_ns         = boot_fsm_ps;
        ready_for_fuses     = 1'b0;
        fw_upd_rst_executed = 1'b0;
        fsm_noncore_rst_b   = 1'b0;
        fsm_uc_rst_b        = 1'b0;
        fsm_iccm_unlock     = 1'b0;
        wait_count_load     = 1'b0;
        wait_count_decr     = 1'b0;

        unique case (boot_fsm_ps)
            // both resets held while the warm reset window is open
            boot_ctrl_pkg::BOOT_IDLE: begin
                if (arc_idle_fuse) begin
                    boot_fsm_ns = boot_ctrl_pkg::BOOT_FUSE;
                end
            end
            // non-core logic runs so the SoC can program the fuses
            boot_ctrl_pkg::BOOT_FUSE: begin
                ready_for_fuses   = 1'b1;
                fsm_noncore_rst_b = 1'b1;
                if (arc_fuse_exit) begin
                    if (brkpoint) begin
                        boot_fsm_ns = boot_ctrl_pkg::BOOT_WAIT;
                    end else begin
                        boot_fsm_ns = boot_ctrl_pkg::BOOT_DONE;
                    end
                end
            end
            // core reset asserted, the wait counter is loaded here
            boot_ctrl_pkg::BOOT_FW_RST: begin
                fsm_noncore_rst_b = 1'b1;
                wait_count_load   = 1'b1;
                if (arc_fwrst_wait) begin
                    boot_fsm_ns = boot_ctrl_pkg::BOOT_WAIT;
                end
            end
            // core still in reset while the counter runs down
            boot_ctrl_pkg::BOOT_WAIT: begin
                fsm_noncore_rst_b = 1'b1;
                wait_count_decr   = 1'b1;
                if (arc_wait_done) begin
                    boot_fsm_ns = boot_ctrl_pkg::BOOT_DONE;
                    // ICCM opens only at the very end of the reset flow
                    fsm_iccm_unlock = 1'b1;
                end
            end
            boot_ctrl_pkg::BOOT_DONE: begin
                fsm_noncore_rst_b = 1'b1;
                fsm_uc_rst_b      = 1'b1;
                if (arc_done_fwrst) begin
                    boot_fsm_ns         = boot_ctrl_pkg::BOOT_FW_RST;
                    fw_upd_rst_executed = 1'b1;
                end
            end
            default: begin
                boot_fsm_ns = boot_ctrl_pkg::BOOT_IDLE;
            end
        endcase
    end

    // state, reset stages and window delay line live on power-good
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            boot_fsm_ps        <= boot_ctrl_pkg::BOOT_IDLE;
            noncore_rst_b_sync <= 1'b0;
            uc_rst_b_sync      <= 1'b0;
            noncore_rst_b_q    <= 1'b0;
            uc_rst_b_q         <= 1'b0;
            rst_window_f       <= 1'b1;
            rst_window_2f      <= 1'b1;
            rst_window_3f      <= 1'b1;
            rst_window_4f      <= 1'b1;
        end else begin
            // a warm reset forces the state back to idle from anywhere
            boot_fsm_ps        <= rst_window_2f ? boot_ctrl_pkg::BOOT_IDLE : boot_fsm_ns;
            noncore_rst_b_sync <= fsm_noncore_rst_b;
            uc_rst_b_sync      <= fsm_uc_rst_b;
            noncore_rst_b_q    <= noncore_rst_b_sync;
            // the core leaves reset only when the non-core side is out too
            uc_rst_b_q         <= noncore_rst_b_sync & uc_rst_b_sync;
            rst_window_f       <= rst_window;
            rst_window_2f      <= rst_window_f;
            rst_window_3f      <= rst_window_2f;
            rst_window_4f      <= rst_window_3f;
        end
    end

    // warm reset domain, the window opens asynchronously on cptra_rst_b
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rst_window  <= 1'b1;
            wait_count  <= 8'd0;
            iccm_unlock <= 1'b0;
        end else begin
            rst_window  <= 1'b0;
            iccm_unlock <= fsm_iccm_unlock;
            if (wait_count_decr && (wait_count != 8'd0)) begin
                wait_count <= wait_count - 8'd1;
            end else if (wait_count_load) begin
                wait_count <= fw_update_rst_wait_cycles;
            end
        end
    end

    // scan mode keeps every generated reset released
    always_comb begin
        rst_out.noncore_rst_b = noncore_rst_b_q | scan_mode;
        rst_out.uc_rst_b      = uc_rst_b_q | scan_mode;
        // clocks stay off for three cycles once the warm reset has been synchronized
        rst_out.rdc_clk_dis   = rst_window_2f | rst_window_3f | rst_window_4f;
        // marks where the core reset moves on its own, apart from warm reset
        rst_out.fw_update_rst_window = (boot_fsm_ps == boot_ctrl_pkg::BOOT_FW_RST) |
                                       (boot_fsm_ps == boot_ctrl_pkg::BOOT_WAIT);
    end

endmodule

`default_nettype wire

// File: hdl/boot_reg_pkg.sv
//==========================================================================
// boot register port types
// request opcode, request bundle and the layout of the status word
//==========================================================================

`default_nettype none

`include "boot_ctrl_defines.svh"

package boot_reg_pkg;

    typedef enum logic {
        REG_READ  = 1'b0,
        REG_WRITE = 1'b1
    } reg_op_e;

    // one register access, sampled on a clock edge with req_valid high
    typedef struct packed {
        reg_op_e                 op;
        logic [`BOOT_ADDR_W-1:0] addr;
        logic [`BOOT_DATA_W-1:0] wdata;
    } reg_req_t;

    // read value of the status register
    typedef struct packed {
        logic [24:0] pad;
        logic        fw_upd_rst_executed;
        logic        ready_for_fuses;
        logic        fuse_done;
        logic [2:0]  boot_state;
        logic        uc_rst_b;
    } boot_status_t;

endpackage

`default_nettype wire

// File: hdl/boot_ctrl_pkg.sv
//==========================================================================
// boot control types
// boot state machine encoding and the bundle of generated resets
//==========================================================================

`default_nettype none

package boot_ctrl_pkg;

    // states of the boot sequencer, BOOT_IDLE is the power-on state
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_FW_RST = 3'd2,
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_fsm_state_e;

    // resets and reset-domain-crossing controls leaving the sequencer
    typedef struct packed {
        logic noncore_rst_b;
        logic uc_rst_b;
        logic rdc_clk_dis;
        logic fw_update_rst_window;
    } rst_out_t;

endpackage

`default_nettype wire

// File: include/boot_ctrl_defines.svh
//==========================================================================
// boot controller definitions
// register port widths, the fuse store size, the register map and the
// reset value of the firmware-update wait field
//==========================================================================

`ifndef BOOT_CTRL_DEFINES_SVH
`define BOOT_CTRL_DEFINES_SVH

// register port widths
`define BOOT_DATA_W 32
`define BOOT_ADDR_W 8

// number of 32-bit fuse words held by the register block
`define BOOT_FUSE_WORDS 4

// reset value of the firmware-update wait cycles field
`define BOOT_FW_WAIT_DEFAULT 8'd20

// register map, the fuse words start at the base and are word aligned
`define ADDR_FUSE_BASE 8'h00
`define ADDR_FUSE_DONE 8'h10
`define ADDR_FW_UPDATE 8'h14
`define ADDR_BOOT_CTRL 8'h18
`define ADDR_STATUS    8'h1C

`endif
